/* kbd_config.svh */
// Keyboard build constants

`ifndef KBD_CONFIG_SVH
`define KBD_CONFIG_SVH

//////////////////////////////
// button debounce
//////////////////////////////

// width of the stable-level counter
// a level must hold 2**bits cycles before it is accepted
// 4 keeps simulation short, hardware wants closer to 18
`define KBD_DEBOUNCE_BITS 4

//////////////////////////////
// ps/2 receiver
//////////////////////////////

// cycles without a ps2_clk falling edge before a partial frame is dropped
`define KBD_PS2_IDLE_CYCLES 64

//////////////////////////////
// cpu keyboard register
//////////////////////////////

// bit of the register byte that flags a key waiting
`define KBD_READY_BIT 7

`endif

/* kbd_pkg.sv */
// Keyboard path types
`default_nettype none

package kbd_pkg;

  //////////////////////////////
  // data words
  //////////////////////////////

  // one raw byte off the ps/2 wire
  typedef logic [7:0] scan_code_t;

  // apple 1 keys are 7-bit upper-case ascii
  typedef logic [6:0] ascii_t;

  //////////////////////////////
  // state encodings
  //////////////////////////////

  // ps/2 frame receiver
  // start bit is taken in idle, so no separate start state
  typedef enum logic [1:0] {
    rx_idle   = 2'd0,
    rx_data   = 2'd1,
    rx_parity = 2'd2,
    rx_stop   = 2'd3
  } rx_state_t;

  // scancode prefix tracking
  // break = after f0, ext = after e0, ext_break = e0 f0
  typedef enum logic [1:0] {
    prefix_none      = 2'd0,
    prefix_break     = 2'd1,
    prefix_ext       = 2'd2,
    prefix_ext_break = 2'd3
  } prefix_t;

  // which device feeds the keyboard register
  typedef enum logic {
    src_ps2  = 1'b0,
    src_uart = 1'b1
  } key_src_t;

endpackage

`default_nettype wire

/* ps2_scan_if.sv */
// PS/2 byte link
`timescale 1ns/1ps
`default_nettype none

// one received frame handed from the receiver to the decoder
// data and both status flags only mean something while strobe is high
interface ps2_scan_if;

  logic                strobe;
  kbd_pkg::scan_code_t data;
  logic                parity_ok;
  logic                framing_ok;

  // frame receiver side
  modport rx (output strobe, output data, output parity_ok, output framing_ok);

  // scancode decoder side
  modport dec (input strobe, input data, input parity_ok, input framing_ok);

endinterface

`default_nettype wire

/* button_debounce.sv */
// Source select debounce
`timescale 1ns/1ps
`default_nettype none
`include "kbd_config.svh"

module button_debounce (
  input  wire  ps2_toggle,
  input  wire  rst,
  input  wire  button,
  output logic select_pulse
);

  // two-stage synchronizer, then the accepted level
  logic                          btn_meta;
  logic                          btn_sync;
  logic                          btn_level;
  logic [`KBD_DEBOUNCE_BITS-1:0] stable_cnt;

  always_ff @(posedge ps2_toggle) begin
    if (rst) begin
      btn_meta     <= 1'b0;
      btn_sync     <= 1'b0;
      btn_level    <= 1'b0;
      stable_cnt   <= '0;
      select_pulse <= 1'b0;
    end else begin
      btn_meta     <= button;
      btn_sync     <= btn_meta;
      select_pulse <= 1'b0;
      if (btn_sync == btn_level) begin
        // no change pending, any bounce restarts the count
        stable_cnt <= '0;
      end else if (&stable_cnt) begin
        // held long enough, take it; pulse only on a press
        btn_level    <= btn_sync;
        stable_cnt   <= '0;
        select_pulse <= btn_sync;
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

  // one press must never look like two source toggles
  a_single_pulse: assert property (@(posedge ps2_toggle) disable iff (rst)
    select_pulse |=> !select_pulse);

endmodule

`default_nettype wire

/* ps2_frame_rx.sv */
// PS/2 frame receiver
`timescale 1ns/1ps
`default_nettype none
`include "kbd_config.svh"

module ps2_frame_rx (
  input wire         ps2_toggle,
  input wire         rst,
  input wire         ps2_clk,
  input wire         ps2_din,
  ps2_scan_if.rx     scan
);

  localparam int IDLE_W = $clog2(`KBD_PS2_IDLE_CYCLES);
  localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(`KBD_PS2_IDLE_CYCLES - 1);

  kbd_pkg::rx_state_t  state;
  logic                clk_meta;
  logic                clk_sync;
  logic                clk_prev;
  logic                din_meta;
  logic                din_sync;
  logic                fall;
  logic [2:0]          bit_cnt;
  logic [IDLE_W-1:0]   idle_cnt;
  logic                start_ok;
  logic                parity_bit;
  kbd_pkg::scan_code_t shift_reg;

  //////////////////////////////
  // line synchronizers
  //////////////////////////////

  // lines idle high, so reset to 1 to avoid a false edge
  always_ff @(posedge ps2_toggle) begin
    if (rst) begin
      clk_meta <= 1'b1;
      clk_sync <= 1'b1;
      clk_prev <= 1'b1;
      din_meta <= 1'b1;
      din_sync <= 1'b1;
    end else begin
      clk_meta <= ps2_clk;
      clk_sync <= clk_meta;
      clk_prev <= clk_sync;
      din_meta <= ps2_din;
      din_sync <= din_meta;
    end
  end

  // device changes data on rising clk, we sample on falling
  assign fall = clk_prev & ~clk_sync;

  //////////////////////////////
  // frame fsm
  //////////////////////////////

  always_ff @(posedge ps2_toggle) begin
    if (rst) begin
      state       <= kbd_pkg::rx_idle;
      bit_cnt     <= '0;
      idle_cnt    <= '0;
      scan.strobe <= 1'b0;
    end else begin
      scan.strobe <= 1'b0;
      // watchdog only runs mid-frame
      if (fall || state == kbd_pkg::rx_idle) idle_cnt <= '0;
      else idle_cnt <= idle_cnt + 1'b1;
      if (fall) begin
        case (state)
          kbd_pkg::rx_idle: begin
            state   <= kbd_pkg::rx_data;
            bit_cnt <= '0;
          end
          kbd_pkg::rx_data: begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= kbd_pkg::rx_parity;
          end
          kbd_pkg::rx_parity: state <= kbd_pkg::rx_stop;
          default: begin
            state       <= kbd_pkg::rx_idle;
            scan.strobe <= 1'b1;
          end
        endcase
      end else if (state != kbd_pkg::rx_idle && idle_cnt == IDLE_LAST) begin
        // lost sync with the keyboard, drop the partial frame
        state <= kbd_pkg::rx_idle;
      end
    end
  end

  // frame payload, lsb first
  always_ff @(posedge ps2_toggle) begin
    if (fall) begin
      case (state)
        kbd_pkg::rx_idle:   start_ok <= ~din_sync;
        kbd_pkg::rx_data:   shift_reg <= {din_sync, shift_reg[7:1]};
        kbd_pkg::rx_parity: parity_bit <= din_sync;
        default: begin
          scan.data       <= shift_reg;
          // odd parity over data plus parity bit
          scan.parity_ok  <= ^{shift_reg, parity_bit};
          scan.framing_ok <= start_ok & din_sync;
        end
      endcase
    end
  end

  // a reported frame always leaves the fsm ready for the next start bit
  a_strobe_idle: assert property (@(posedge ps2_toggle) disable iff (rst)
    scan.strobe |-> state == kbd_pkg::rx_idle);

endmodule

`default_nettype wire

/* scancode_decode.sv */
// Set-2 scancode decoder
`timescale 1ns/1ps
`default_nettype none

module scancode_decode (
  input  wire             ps2_toggle,
  input  wire             rst,
  ps2_scan_if.dec         scan,
  output logic            ps2_key_strobe,
  output kbd_pkg::ascii_t ps2_key_ascii
);

  kbd_pkg::prefix_t prefix;
  logic             shift_held;
  logic             frame_good;
  logic             map_valid;
  kbd_pkg::ascii_t  map_ascii;

  assign frame_good = scan.parity_ok & scan.framing_ok;

  //////////////////////////////
  // make code table
  //////////////////////////////

  always_comb begin
    map_valid = 1'b1;
    map_ascii = '0;
    case (scan.data)
      // letters, always upper case on the apple 1
      8'h1c: map_ascii = 7'h41;
      8'h32: map_ascii = 7'h42;
      8'h21: map_ascii = 7'h43;
      8'h23: map_ascii = 7'h44;
      8'h24: map_ascii = 7'h45;
      8'h2b: map_ascii = 7'h46;
      8'h34: map_ascii = 7'h47;
      8'h33: map_ascii = 7'h48;
      8'h43: map_ascii = 7'h49;
      8'h3b: map_ascii = 7'h4a;
      8'h42: map_ascii = 7'h4b;
      8'h4b: map_ascii = 7'h4c;
      8'h3a: map_ascii = 7'h4d;
      8'h31: map_ascii = 7'h4e;
      8'h44: map_ascii = 7'h4f;
      8'h4d: map_ascii = 7'h50;
      8'h15: map_ascii = 7'h51;
      8'h2d: map_ascii = 7'h52;
      8'h1b: map_ascii = 7'h53;
      8'h2c: map_ascii = 7'h54;
      8'h3c: map_ascii = 7'h55;
      8'h2a: map_ascii = 7'h56;
      8'h1d: map_ascii = 7'h57;
      8'h22: map_ascii = 7'h58;
      8'h35: map_ascii = 7'h59;
      8'h1a: map_ascii = 7'h5a;
      // number row, us layout symbols under shift
      8'h45: map_ascii = shift_held ? 7'h29 : 7'h30;
      8'h16: map_ascii = shift_held ? 7'h21 : 7'h31;
      8'h1e: map_ascii = shift_held ? 7'h40 : 7'h32;
      8'h26: map_ascii = shift_held ? 7'h23 : 7'h33;
      8'h25: map_ascii = shift_held ? 7'h24 : 7'h34;
      8'h2e: map_ascii = shift_held ? 7'h25 : 7'h35;
      8'h36: map_ascii = shift_held ? 7'h5e : 7'h36;
      8'h3d: map_ascii = shift_held ? 7'h26 : 7'h37;
      8'h3e: map_ascii = shift_held ? 7'h2a : 7'h38;
      8'h46: map_ascii = shift_held ? 7'h28 : 7'h39;
      // space, return, and backspace as the apple 1 rubout underscore
      8'h29: map_ascii = 7'h20;
      8'h5a: map_ascii = 7'h0d;
      8'h66: map_ascii = 7'h5f;
      default: map_valid = 1'b0;
    endcase
  end

  //////////////////////////////
  // prefix and shift tracking
  //////////////////////////////

  always_ff @(posedge ps2_toggle) begin
    if (rst) begin
      prefix         <= kbd_pkg::prefix_none;
      shift_held     <= 1'b0;
      ps2_key_strobe <= 1'b0;
    end else begin
      ps2_key_strobe <= 1'b0;
      if (scan.strobe) begin
        if (!frame_good) begin
          // corrupt byte, whatever sequence it belonged to is lost
          prefix <= kbd_pkg::prefix_none;
        end else begin
          case (scan.data)
            8'hf0: prefix <= (prefix == kbd_pkg::prefix_ext) ?
                             kbd_pkg::prefix_ext_break : kbd_pkg::prefix_break;
            8'he0: prefix <= kbd_pkg::prefix_ext;
            8'h12, 8'h59: begin
              // e0 12 is a fake shift, leave the level alone
              if (prefix == kbd_pkg::prefix_none) shift_held <= 1'b1;
              else if (prefix == kbd_pkg::prefix_break) shift_held <= 1'b0;
              prefix <= kbd_pkg::prefix_none;
            end
            default: begin
              // releases and every extended key give nothing
              if (prefix == kbd_pkg::prefix_none && map_valid) ps2_key_strobe <= 1'b1;
              prefix <= kbd_pkg::prefix_none;
            end
          endcase
        end
      end
    end
  end

  always_ff @(posedge ps2_toggle) begin
    if (scan.strobe && map_valid) ps2_key_ascii <= map_ascii;
  end

  // every key comes from a good frame one cycle earlier and is known 7-bit ascii
  a_key_from_frame: assert property (@(posedge ps2_toggle) disable iff (rst)
    ps2_key_strobe |-> ($past(scan.strobe && frame_good) &&
                        !$isunknown(ps2_key_ascii)));

endmodule

`default_nettype wire

/* key_port.sv */
// Apple 1 keyboard register
`timescale 1ns/1ps
`default_nettype none
`include "kbd_config.svh"

module key_port (
  input  wire               ps2_toggle,
  input  wire               rst,
  input  wire               ps2_key_strobe,
  input  kbd_pkg::ascii_t   ps2_key_ascii,
  input  wire               uart_strobe,
  input  wire  [7:0]        uart_data,
  input  wire               select_pulse,
  input  wire               kbd_rd,
  output logic [7:0]        kbd_data,
  output kbd_pkg::key_src_t key_source
);

  logic            sel_strobe;
  kbd_pkg::ascii_t sel_ascii;

  //////////////////////////////
  // source mux
  //////////////////////////////

  // the idle source is ignored entirely
  // serial bytes lose bit 7, the register owns it
  always_comb begin
    if (key_source == kbd_pkg::src_ps2) begin
      sel_strobe = ps2_key_strobe;
      sel_ascii  = ps2_key_ascii;
    end else begin
      sel_strobe = uart_strobe;
      sel_ascii  = uart_data[6:0];
    end
  end

  //////////////////////////////
  // register and source toggle
  //////////////////////////////

  always_ff @(posedge ps2_toggle) begin
    if (rst) begin
      kbd_data   <= '0;
      key_source <= kbd_pkg::src_ps2;
    end else begin
      if (select_pulse) begin
        key_source <= (key_source == kbd_pkg::src_ps2) ?
                      kbd_pkg::src_uart : kbd_pkg::src_ps2;
      end
      if (sel_strobe) begin
        // an unread key is simply overwritten
        kbd_data[6:0]            <= sel_ascii;
        kbd_data[`KBD_READY_BIT] <= 1'b1;
      end else if (kbd_rd) begin
        // cpu took it, keep the last code visible
        kbd_data[`KBD_READY_BIT] <= 1'b0;
      end
    end
  end

  // a read with no competing key always drops the ready flag
  a_read_clears: assert property (@(posedge ps2_toggle) disable iff (rst)
    (kbd_rd && !sel_strobe) |=> !kbd_data[`KBD_READY_BIT]);

endmodule

`default_nettype wire

/* kbd_top.sv */
// Keyboard input subsystem
`timescale 1ns/1ps
`default_nettype none

module kbd_top (
  input  wire               ps2_toggle,
  input  wire               rst,
  input  wire               ps2_clk,
  input  wire               ps2_din,
  input  wire               button,
  input  wire               uart_strobe,
  input  wire  [7:0]        uart_data,
  input  wire               kbd_rd,
  output logic [7:0]        kbd_data,
  output kbd_pkg::key_src_t key_source
);

  // receiver to decoder byte link
  ps2_scan_if scan_bus ();

  logic            select_pulse;
  logic            ps2_key_strobe;
  kbd_pkg::ascii_t ps2_key_ascii;

  //////////////////////////////
  // decode
  //////////////////////////////

  ps2_frame_rx ps2_frame_rx_inst (
    .ps2_toggle (ps2_toggle),
    .rst        (rst),
    .ps2_clk    (ps2_clk),
    .ps2_din    (ps2_din),
    .scan       (scan_bus.rx)
  );

  scancode_decode scancode_decode_inst (
    .ps2_toggle     (ps2_toggle),
    .rst            (rst),
    .scan           (scan_bus.dec),
    .ps2_key_strobe (ps2_key_strobe),
    .ps2_key_ascii  (ps2_key_ascii)
  );

  //////////////////////////////
  // execute
  //////////////////////////////

  button_debounce button_debounce_inst (
    .ps2_toggle   (ps2_toggle),
    .rst          (rst),
    .button       (button),
    .select_pulse (select_pulse)
  );

  // register output is the cpu-facing result
  key_port key_port_inst (
    .ps2_toggle     (ps2_toggle),
    .rst            (rst),
    .ps2_key_strobe (ps2_key_strobe),
    .ps2_key_ascii  (ps2_key_ascii),
    .uart_strobe    (uart_strobe),
    .uart_data      (uart_data),
    .select_pulse   (select_pulse),
    .kbd_rd         (kbd_rd),
    .kbd_data       (kbd_data),
    .key_source     (key_source)
  );

endmodule

`default_nettype wire

/* tb_kbd_top.sv */
// Keyboard path testbench
`timescale 1ns/1ps
`default_nettype none
`include "kbd_config.svh"

module tb_kbd_top;

  // what a table row does to the DUT
  typedef enum int {act_key, act_nokey, act_badpar, act_read, act_uart, act_button} act_t;

  // codes are sent most significant byte first, n of them
  typedef struct {
    string             name;
    act_t              act;
    logic [31:0]       codes;
    int                n;
    logic [7:0]        uart;
    logic [7:0]        exp_data;
    kbd_pkg::key_src_t exp_src;
  } row_t;

  localparam int KEY_TIMEOUT = 400;
  // set-2 make codes for A..Z, A in the low byte
  localparam logic [207:0] LETTER_CODES =
    208'h1a35221d_2a3c2c1b_2d154d44_313a4b42_3b433334_2b242321_321c;

  logic              ps2_toggle;
  logic              rst;
  logic              ps2_clk;
  logic              ps2_din;
  logic              button;
  logic              uart_strobe;
  logic [7:0]        uart_data;
  logic              kbd_rd;
  wire  [7:0]        kbd_data;
  kbd_pkg::key_src_t key_source;
  row_t              rows[$];
  logic [31:0]       rnd;
  logic [7:0]        letter_idx;

  kbd_top kbd_top_inst (
    .ps2_toggle  (ps2_toggle),
    .rst         (rst),
    .ps2_clk     (ps2_clk),
    .ps2_din     (ps2_din),
    .button      (button),
    .uart_strobe (uart_strobe),
    .uart_data   (uart_data),
    .kbd_rd      (kbd_rd),
    .kbd_data    (kbd_data),
    .key_source  (key_source)
  );

  // 4 ns system clock
  initial ps2_toggle = 1'b0;
  always #2 ps2_toggle = ~ps2_toggle;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_row(input string name, input act_t act, input logic [31:0] codes,
                         input int n, input logic [7:0] uart, input logic [7:0] exp_data,
                         input kbd_pkg::key_src_t exp_src);
    rows.push_back('{name, act, codes, n, uart, exp_data, exp_src});
  endtask

  task automatic check_data(input string name, input logic [7:0] exp);
    if (kbd_data !== exp) begin
      $display("Mismatch %s expected %02h actual %02h", name, exp, kbd_data);
      $display("Simulation failed");
      $fatal(1, "kbd_data check failed");
    end
  endtask

  task automatic check_source(input string name, input kbd_pkg::key_src_t exp);
    if (key_source !== exp) begin
      $display("Mismatch %s expected %s actual %s", name, exp.name(), key_source.name());
      $display("Simulation failed");
      $fatal(1, "key_source check failed");
    end
  endtask

  // device side of one frame: data set while clk high, host samples on the fall
  task automatic send_frame(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, ~^code ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      @(negedge ps2_toggle);
      ps2_din = frame[i];
      repeat (8) @(negedge ps2_toggle);
      ps2_clk = 1'b0;
      repeat (8) @(negedge ps2_toggle);
      ps2_clk = 1'b1;
    end
    repeat (8) @(negedge ps2_toggle);
  endtask

  task automatic wait_ready(input string name);
    int cycles;
    cycles = 0;
    while (kbd_data[`KBD_READY_BIT] !== 1'b1) begin
      if (cycles == KEY_TIMEOUT) begin
        $display("no key arrived within %0d cycles in test %s", KEY_TIMEOUT, name);
        $display("Simulation failed");
        $fatal(1, "key wait timed out");
      end
      @(negedge ps2_toggle);
      cycles++;
    end
  endtask

  // ready must stay low over the whole window
  task automatic wait_no_key(input string name);
    for (int i = 0; i < KEY_TIMEOUT; i++) begin
      @(negedge ps2_toggle);
      if (kbd_data[`KBD_READY_BIT] !== 1'b0) begin
        $display("a key arrived in test %s where none was expected", name);
        $display("Simulation failed");
        $fatal(1, "unexpected key");
      end
    end
  endtask

  task automatic wait_source(input string name, input kbd_pkg::key_src_t target);
    int cycles;
    cycles = 0;
    while (key_source !== target) begin
      if (cycles == KEY_TIMEOUT) begin
        $display("key source never switched in test %s", name);
        $display("Simulation failed");
        $fatal(1, "source wait timed out");
      end
      @(negedge ps2_toggle);
      cycles++;
    end
  endtask

  task automatic pulse_read();
    @(negedge ps2_toggle);
    kbd_rd = 1'b1;
    @(negedge ps2_toggle);
    kbd_rd = 1'b0;
  endtask

  //////////////////////////////
  // row execution
  //////////////////////////////

  task automatic apply_row(input row_t r);
    for (int i = r.n - 1; i >= 0; i--) begin
      send_frame(r.codes[8*i +: 8], r.act == act_badpar);
    end
    case (r.act)
      act_key: wait_ready(r.name);
      act_nokey, act_badpar: wait_no_key(r.name);
      act_read: pulse_read();
      act_uart: begin
        @(negedge ps2_toggle);
        uart_strobe = 1'b1;
        uart_data   = r.uart;
        @(negedge ps2_toggle);
        uart_strobe = 1'b0;
        wait_ready(r.name);
      end
      default: begin
        // hold the button until the source flips, then let release settle
        button = 1'b1;
        wait_source(r.name, r.exp_src);
        button = 1'b0;
        repeat ((1 << `KBD_DEBOUNCE_BITS) + 8) @(negedge ps2_toggle);
      end
    endcase
    check_data(r.name, r.exp_data);
    check_source(r.name, r.exp_src);
  endtask

  task automatic build_table();
    add_row("letter_a", act_key, 32'h1c, 1, 8'h00, 8'hc1, kbd_pkg::src_ps2);
    add_row("read_a", act_read, 32'h0, 0, 8'h00, 8'h41, kbd_pkg::src_ps2);
    // shift make, 1, shift break gives the bang
    add_row("shift_one", act_key, 32'h1216f012, 4, 8'h00, 8'ha1, kbd_pkg::src_ps2);
    add_row("read_bang", act_read, 32'h0, 0, 8'h00, 8'h21, kbd_pkg::src_ps2);
    add_row("break_a", act_nokey, 32'hf01c, 2, 8'h00, 8'h21, kbd_pkg::src_ps2);
    // keypad enter shares 5a with return, only the e0 keeps it out
    add_row("ext_enter", act_nokey, 32'he05a, 2, 8'h00, 8'h21, kbd_pkg::src_ps2);
    add_row("unmapped_f1", act_nokey, 32'h05, 1, 8'h00, 8'h21, kbd_pkg::src_ps2);
    add_row("after_drop", act_key, 32'h2d, 1, 8'h00, 8'hd2, kbd_pkg::src_ps2);
    add_row("read_r", act_read, 32'h0, 0, 8'h00, 8'h52, kbd_pkg::src_ps2);
    add_row("bad_parity", act_badpar, 32'h1b, 1, 8'h00, 8'h52, kbd_pkg::src_ps2);
    add_row("good_after_bad", act_key, 32'h1b, 1, 8'h00, 8'hd3, kbd_pkg::src_ps2);
    // S is still unread here
    add_row("overwrite_w", act_key, 32'h1d, 1, 8'h00, 8'hd7, kbd_pkg::src_ps2);
    add_row("read_w", act_read, 32'h0, 0, 8'h00, 8'h57, kbd_pkg::src_ps2);
    add_row("press_uart", act_button, 32'h0, 0, 8'h00, 8'h57, kbd_pkg::src_uart);
    add_row("uart_j", act_uart, 32'h0, 0, 8'h4a, 8'hca, kbd_pkg::src_uart);
    add_row("read_j", act_read, 32'h0, 0, 8'h00, 8'h4a, kbd_pkg::src_uart);
    add_row("ps2_ignored", act_nokey, 32'h1c, 1, 8'h00, 8'h4a, kbd_pkg::src_uart);
    add_row("press_ps2", act_button, 32'h0, 0, 8'h00, 8'h4a, kbd_pkg::src_ps2);
    add_row("ps2_back", act_key, 32'h1c, 1, 8'h00, 8'hc1, kbd_pkg::src_ps2);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst         = 1'b1;
    ps2_clk     = 1'b1;
    ps2_din     = 1'b1;
    button      = 1'b0;
    uart_strobe = 1'b0;
    uart_data   = 8'h00;
    kbd_rd      = 1'b0;
    rnd         = 32'h45e71feb;
    build_table();
    repeat (4) @(negedge ps2_toggle);
    rst = 1'b0;
    check_data("reset", 8'h00);
    check_source("reset", kbd_pkg::src_ps2);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    // random letters, each read out first so ready rises fresh
    for (int k = 0; k < 16; k++) begin
      rnd        = xorshift(rnd);
      letter_idx = 8'(rnd % 32'd26);
      pulse_read();
      send_frame(LETTER_CODES[8*letter_idx +: 8], 1'b0);
      wait_ready($sformatf("random_%0d", k));
      check_data($sformatf("random_%0d", k), 8'h80 | (8'h41 + letter_idx));
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
kbd_pkg.sv
ps2_scan_if.sv
button_debounce.sv
ps2_frame_rx.sv
scancode_decode.sv
key_port.sv
kbd_top.sv
tb_kbd_top.sv

/* Makefile */
# Verilator flow for the keyboard input path

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module tb_kbd_top -o sim_kbd

# pass only if the testbench printed its pass line
run: build
	./obj_dir/sim_kbd | tee sim.log
	grep -q "Simulation passed" sim.log

lint:
	verilator --lint-only --timing -f src.f --top-module kbd_top

clean:
	rm -rf obj_dir sim.log
